//--- source/control_pkg.sv
`default_nettype none

package control_pkg;

	localparam int OPCODE_W = 6; // Instruction opcode field
	localparam int ALU_OP_W = 4; // ALU function code
	localparam int PC_SEL_W = 2; // PC adder select
	localparam int WB_SEL_W = 2; // Register write-back source
	localparam int BR_COND_W = 3; // Decoded branch condition

	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [ALU_OP_W-1:0] alu_op_t;
	typedef logic [PC_SEL_W-1:0] pc_sel_t;
	typedef logic [WB_SEL_W-1:0] wb_sel_t;
	typedef logic [BR_COND_W-1:0] branch_cond_t;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_MUL = 4'd2;
	localparam alu_op_t ALU_DIV = 4'd3;
	localparam alu_op_t ALU_AND = 4'd4;
	localparam alu_op_t ALU_OR = 4'd5;
	localparam alu_op_t ALU_XOR = 4'd6;
	localparam alu_op_t ALU_NOT = 4'd7; // Unary on rs
	localparam alu_op_t ALU_SHL = 4'd8;
	localparam alu_op_t ALU_SHR = 4'd9;
	localparam alu_op_t ALU_PASS_A = 4'd10; // rd = rs
	localparam alu_op_t ALU_PASS_IMM = 4'd11; // Result is the immediate

	localparam pc_sel_t PC_HOLD = 2'd0; // PC unchanged
	localparam pc_sel_t PC_INC = 2'd1; // PC + 1
	localparam pc_sel_t PC_BRANCH = 2'd2; // Relative branch target
	localparam pc_sel_t PC_JUMP = 2'd3; // Absolute jump target

	localparam wb_sel_t WB_NONE = 2'd0;
	localparam wb_sel_t WB_ALU = 2'd1;
	localparam wb_sel_t WB_MEM = 2'd2; // Data memory read word
	localparam wb_sel_t WB_INPUT = 2'd3; // External input port

	localparam branch_cond_t BR_NONE = 3'd0; // Not a conditional branch
	localparam branch_cond_t BR_EQ = 3'd1;
	localparam branch_cond_t BR_NE = 3'd2;
	localparam branch_cond_t BR_LT = 3'd3;
	localparam branch_cond_t BR_LE = 3'd4;
	localparam branch_cond_t BR_GT = 3'd5;
	localparam branch_cond_t BR_GE = 3'd6;

	// Opcode map, immediate forms sit one above their register forms
	localparam opcode_t OP_NOP = 6'd0;
	localparam opcode_t OP_ADD = 6'd1;
	localparam opcode_t OP_ADDI = 6'd2;
	localparam opcode_t OP_SUB = 6'd3;
	localparam opcode_t OP_SUBI = 6'd4;
	localparam opcode_t OP_MUL = 6'd5;
	localparam opcode_t OP_MULI = 6'd6;
	localparam opcode_t OP_DIV = 6'd7;
	localparam opcode_t OP_DIVI = 6'd8;
	localparam opcode_t OP_AND = 6'd9;
	localparam opcode_t OP_ANDI = 6'd10;
	localparam opcode_t OP_OR = 6'd11;
	localparam opcode_t OP_ORI = 6'd12;
	localparam opcode_t OP_XOR = 6'd13;
	localparam opcode_t OP_XORI = 6'd14;
	localparam opcode_t OP_NOT = 6'd15;
	localparam opcode_t OP_SL = 6'd16;
	localparam opcode_t OP_SR = 6'd17;
	localparam opcode_t OP_MOV = 6'd18;
	localparam opcode_t OP_LW = 6'd19;
	localparam opcode_t OP_LI = 6'd20;
	localparam opcode_t OP_LA = 6'd21; // Decodes as NOP
	localparam opcode_t OP_SW = 6'd22;
	localparam opcode_t OP_BEQ = 6'd23;
	localparam opcode_t OP_BNE = 6'd24;
	localparam opcode_t OP_BLT = 6'd25;
	localparam opcode_t OP_BLET = 6'd26;
	localparam opcode_t OP_BGT = 6'd27;
	localparam opcode_t OP_BGET = 6'd28;
	localparam opcode_t OP_J = 6'd29;
	localparam opcode_t OP_JAL = 6'd30; // Decodes as NOP
	localparam opcode_t OP_JR = 6'd31; // Decodes as NOP
	localparam opcode_t OP_IN = 6'd32;
	localparam opcode_t OP_OUT = 6'd33;
	localparam opcode_t OP_RESET = 6'd62;
	localparam opcode_t OP_HALT = 6'd63;

endpackage

`default_nettype wire

//--- source/instruction_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module instruction_decoder (
	input wire control_pkg::opcode_t opcode,
	output logic rd_sel, // 1 selects rd field as destination
	output logic alu_src, // 1 feeds the immediate to the ALU
	output control_pkg::wb_sel_t wb_sel,
	output control_pkg::alu_op_t alu_op,
	output control_pkg::pc_sel_t dec_pc_sel, // Before branch resolution
	output control_pkg::branch_cond_t branch_cond,
	output logic dec_reg_write,
	output logic dec_mem_write,
	output logic dec_out,
	output logic is_in,
	output logic is_halt,
	output logic is_reset
);
	import control_pkg::*;

	always_comb begin
		rd_sel = 1'b0;
		alu_src = 1'b0;
		wb_sel = WB_NONE;
		alu_op = ALU_ADD;
		dec_pc_sel = PC_INC; // Most instructions just step
		branch_cond = BR_NONE;
		dec_reg_write = 1'b0;
		dec_mem_write = 1'b0;
		dec_out = 1'b0;
		is_in = 1'b0;
		is_halt = 1'b0;
		is_reset = 1'b0;

		case (opcode)
			OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL, OP_MULI, OP_DIV, OP_DIVI,
			OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI: begin
				rd_sel = opcode[0]; // Odd opcode is the register form
				alu_src = ~opcode[0]; // Even opcode takes the immediate
				alu_op = alu_op_t'((opcode - OP_ADD) >> 1); // Each pair maps to one ALU op
				wb_sel = WB_ALU;
				dec_reg_write = 1'b1;
			end
			OP_NOT: begin
				alu_op = ALU_NOT;
				wb_sel = WB_ALU;
				dec_reg_write = 1'b1;
			end
			OP_SL, OP_SR: begin
				rd_sel = 1'b1;
				alu_op = (opcode == OP_SL) ? ALU_SHL : ALU_SHR;
				wb_sel = WB_ALU;
				dec_reg_write = 1'b1;
			end
			OP_MOV: begin
				alu_op = ALU_PASS_A;
				wb_sel = WB_ALU;
				dec_reg_write = 1'b1;
			end
			OP_LW, OP_LI: begin
				alu_src = 1'b1;
				alu_op = ALU_PASS_IMM; // Immediate is the address or the value
				wb_sel = (opcode == OP_LW) ? WB_MEM : WB_ALU;
				dec_reg_write = 1'b1;
			end
			OP_SW: begin
				alu_src = 1'b1;
				alu_op = ALU_PASS_IMM; // Store address from immediate
				dec_mem_write = 1'b1;
			end
			OP_BEQ: branch_cond = BR_EQ;
			OP_BNE: branch_cond = BR_NE;
			OP_BLT: branch_cond = BR_LT;
			OP_BLET: branch_cond = BR_LE;
			OP_BGT: branch_cond = BR_GT;
			OP_BGET: branch_cond = BR_GE;
			OP_J: dec_pc_sel = PC_JUMP;
			OP_IN: begin
				wb_sel = WB_INPUT; // Written only once the input is accepted
				dec_reg_write = 1'b1;
				is_in = 1'b1;
			end
			OP_OUT: begin
				alu_src = 1'b1;
				alu_op = ALU_PASS_IMM; // Output port address
				dec_out = 1'b1;
			end
			OP_HALT: begin
				dec_pc_sel = PC_HOLD;
				is_halt = 1'b1;
			end
			OP_RESET: begin
				dec_pc_sel = PC_HOLD;
				is_reset = 1'b1;
			end
			default: ; // NOP, LA, JAL, JR and unused codes only step the PC
		endcase

		if (branch_cond != BR_NONE) begin
			alu_src = 1'b1; // Branch offset comes from the immediate
			alu_op = ALU_PASS_IMM;
		end
	end

	// A store never also writes the register file
	always_comb begin
		assert (!(dec_reg_write && dec_mem_write))
			else $error("decoder drives register and memory write together");
	end

endmodule

`default_nettype wire

//--- source/wait_controller.sv
`default_nettype none
`timescale 1ns/1ps

module wait_controller (
	input wire clock,
	input wire reset,
	input wire restart, // One-cycle strobe seen only while halted
	input wire input_valid, // One-cycle strobe seen only while waiting
	input wire is_in,
	input wire is_halt,
	input wire is_reset,
	output logic stall, // No writes, PC holds
	output logic input_accept, // Input word written this cycle
	output logic restart_pc // PC reset requested
);

	typedef enum logic [1:0] {
		RUNNING,
		WAIT_INPUT,
		HALTED
	} wait_state_t;

	wait_state_t state;
	wait_state_t state_next;

	always_comb begin
		state_next = state;
		stall = 1'b0;
		input_accept = 1'b0;
		restart_pc = 1'b0;

		if (reset) begin
			stall = 1'b1; // Nothing issues during reset
			state_next = RUNNING;
		end else if (is_reset) begin
			restart_pc = 1'b1; // RESET opcode wins in every state
			state_next = RUNNING;
		end else begin
			case (state)
				RUNNING: begin
					if (is_in) begin
						stall = 1'b1; // First IN cycle always stalls
						state_next = WAIT_INPUT;
					end else if (is_halt) begin
						stall = 1'b1;
						state_next = HALTED;
					end
				end
				WAIT_INPUT: begin
					if (input_valid) begin
						input_accept = 1'b1;
						state_next = RUNNING;
					end else begin
						stall = 1'b1;
					end
				end
				HALTED: begin
					if (restart) begin
						restart_pc = 1'b1;
						state_next = RUNNING;
					end else begin
						stall = 1'b1; // input_valid is ignored here
					end
				end
				default: state_next = RUNNING;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) state <= RUNNING;
		else state <= state_next;
	end

	// A release cycle is never also a stall cycle
	release_not_stalled: assert property (@(posedge clock) disable iff (reset)
		(input_accept || restart_pc) |-> !stall);

endmodule

`default_nettype wire

//--- source/issue_control.sv
`default_nettype none
`timescale 1ns/1ps

module issue_control (
	input wire stall,
	input wire input_accept,
	input wire restart_pc,
	input wire control_pkg::pc_sel_t dec_pc_sel,
	input wire control_pkg::branch_cond_t branch_cond,
	input wire less,
	input wire greater,
	input wire equal,
	input wire dec_reg_write,
	input wire dec_mem_write,
	input wire dec_out,
	output control_pkg::pc_sel_t pc_sel,
	output logic pc_write,
	output logic pc_reset,
	output logic reg_write,
	output logic mem_write,
	output logic out_strobe
);
	import control_pkg::*;

	logic branch_taken;
	pc_sel_t resolved_pc_sel;

	always_comb begin
		case (branch_cond)
			BR_EQ: branch_taken = equal;
			BR_NE: branch_taken = !equal;
			BR_LT: branch_taken = less;
			BR_LE: branch_taken = less || equal;
			BR_GT: branch_taken = greater;
			BR_GE: branch_taken = greater || equal;
			default: branch_taken = 1'b0; // BR_NONE and spare codes
		endcase
	end

	always_comb begin
		if (input_accept) resolved_pc_sel = PC_INC; // IN completes and steps on
		else if (branch_cond != BR_NONE) resolved_pc_sel = branch_taken ? PC_BRANCH : PC_INC;
		else resolved_pc_sel = dec_pc_sel;
	end

	always_comb begin
		pc_sel = PC_HOLD;
		pc_write = 1'b0;
		pc_reset = 1'b0;
		reg_write = 1'b0;
		mem_write = 1'b0;
		out_strobe = 1'b0;

		if (restart_pc) begin
			pc_reset = 1'b1; // PC cleared, nothing else moves
		end else if (!stall) begin
			pc_sel = resolved_pc_sel;
			pc_write = 1'b1;
			reg_write = dec_reg_write;
			mem_write = dec_mem_write;
			out_strobe = dec_out;
		end
	end

	always_comb begin
		assert (!(pc_reset && pc_write))
			else $error("pc_reset and pc_write active together");
		// An accepted input only ever completes an IN
		assert (!input_accept || dec_reg_write)
			else $error("input accepted without a register write");
	end

endmodule

`default_nettype wire

//--- source/control_unit.sv
`default_nettype none
`timescale 1ns/1ps

module control_unit (
	input wire clock,
	input wire reset,
	input wire restart, // Leaves HALT
	input wire input_valid, // External input word ready
	input wire control_pkg::opcode_t opcode,
	input wire less, // ALU compare flags
	input wire greater,
	input wire equal,
	output logic rd_sel,
	output logic alu_src,
	output control_pkg::wb_sel_t wb_sel,
	output control_pkg::alu_op_t alu_op,
	output control_pkg::pc_sel_t pc_sel,
	output logic pc_write,
	output logic pc_reset,
	output logic reg_write,
	output logic mem_write,
	output logic out_strobe
);
	import control_pkg::*;

	pc_sel_t dec_pc_sel;
	branch_cond_t branch_cond;
	logic dec_reg_write;
	logic dec_mem_write;
	logic dec_out;
	logic is_in;
	logic is_halt;
	logic is_reset;
	logic stall;
	logic input_accept;
	logic restart_pc;

	instruction_decoder instruction_decoder_inst (
		.opcode(opcode),
		.rd_sel(rd_sel),
		.alu_src(alu_src),
		.wb_sel(wb_sel),
		.alu_op(alu_op),
		.dec_pc_sel(dec_pc_sel),
		.branch_cond(branch_cond),
		.dec_reg_write(dec_reg_write),
		.dec_mem_write(dec_mem_write),
		.dec_out(dec_out),
		.is_in(is_in),
		.is_halt(is_halt),
		.is_reset(is_reset)
	);

	wait_controller wait_controller_inst (
		.clock(clock),
		.reset(reset),
		.restart(restart),
		.input_valid(input_valid),
		.is_in(is_in),
		.is_halt(is_halt),
		.is_reset(is_reset),
		.stall(stall),
		.input_accept(input_accept),
		.restart_pc(restart_pc)
	);

	issue_control issue_control_inst (
		.stall(stall),
		.input_accept(input_accept),
		.restart_pc(restart_pc),
		.dec_pc_sel(dec_pc_sel),
		.branch_cond(branch_cond),
		.less(less),
		.greater(greater),
		.equal(equal),
		.dec_reg_write(dec_reg_write),
		.dec_mem_write(dec_mem_write),
		.dec_out(dec_out),
		.pc_sel(pc_sel),
		.pc_write(pc_write),
		.pc_reset(pc_reset),
		.reg_write(reg_write),
		.mem_write(mem_write),
		.out_strobe(out_strobe)
	);

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock
);

	localparam int HALF_PERIOD_NS = 2; // 4 ns period

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD_NS clock = ~clock;
	end

endmodule

`default_nettype wire

//--- verif/control_unit_tb.sv
`default_nettype none
`timescale 1ns/1ps

module control_unit_tb;
	import control_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 2000; // Tests need about 150 cycles, wide margin

	typedef enum {MODEL_RUNNING, MODEL_WAIT_INPUT, MODEL_HALTED} model_state_t;

	logic clock;
	logic reset;
	logic restart;
	logic input_valid;
	opcode_t opcode;
	logic less;
	logic greater;
	logic equal;
	logic rd_sel;
	logic alu_src;
	wb_sel_t wb_sel;
	alu_op_t alu_op;
	pc_sel_t pc_sel;
	logic pc_write;
	logic pc_reset;
	logic reg_write;
	logic mem_write;
	logic out_strobe;

	logic hold_reset; // Level driven onto reset at the next cycle
	int cycle_count;
	model_state_t model_state; // Expected wait state this cycle
	model_state_t model_next;

	// Reference decode of the current opcode
	logic exp_rd_sel;
	logic exp_alu_src;
	wb_sel_t exp_wb_sel;
	alu_op_t exp_alu_op;
	pc_sel_t exp_pc_sel;
	logic exp_reg_write;
	logic exp_mem_write;
	logic exp_out;
	logic exp_is_branch;

	tb_clock_gen tb_clock_gen_inst (
		.clock(clock)
	);

	control_unit control_unit_inst (
		.clock(clock),
		.reset(reset),
		.restart(restart),
		.input_valid(input_valid),
		.opcode(opcode),
		.less(less),
		.greater(greater),
		.equal(equal),
		.rd_sel(rd_sel),
		.alu_src(alu_src),
		.wb_sel(wb_sel),
		.alu_op(alu_op),
		.pc_sel(pc_sel),
		.pc_write(pc_write),
		.pc_reset(pc_reset),
		.reg_write(reg_write),
		.mem_write(mem_write),
		.out_strobe(out_strobe)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			$display("[ERROR] %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic alu_reg_form(input alu_op_t op); // rd destination, rt operand
		exp_rd_sel = 1'b1;
		exp_alu_op = op;
		exp_wb_sel = WB_ALU;
		exp_reg_write = 1'b1;
	endtask

	task automatic alu_imm_form(input alu_op_t op); // rt destination, immediate operand
		exp_alu_src = 1'b1;
		exp_alu_op = op;
		exp_wb_sel = WB_ALU;
		exp_reg_write = 1'b1;
	endtask

	task automatic decode_reference(input opcode_t op);
		exp_rd_sel = 1'b0;
		exp_alu_src = 1'b0;
		exp_wb_sel = WB_NONE;
		exp_alu_op = ALU_ADD;
		exp_pc_sel = PC_INC; // NOP and unused codes just step
		exp_reg_write = 1'b0;
		exp_mem_write = 1'b0;
		exp_out = 1'b0;
		exp_is_branch = 1'b0;
		case (op)
			OP_ADD: alu_reg_form(ALU_ADD);
			OP_ADDI: alu_imm_form(ALU_ADD);
			OP_SUB: alu_reg_form(ALU_SUB);
			OP_SUBI: alu_imm_form(ALU_SUB);
			OP_MUL: alu_reg_form(ALU_MUL);
			OP_MULI: alu_imm_form(ALU_MUL);
			OP_DIV: alu_reg_form(ALU_DIV);
			OP_DIVI: alu_imm_form(ALU_DIV);
			OP_AND: alu_reg_form(ALU_AND);
			OP_ANDI: alu_imm_form(ALU_AND);
			OP_OR: alu_reg_form(ALU_OR);
			OP_ORI: alu_imm_form(ALU_OR);
			OP_XOR: alu_reg_form(ALU_XOR);
			OP_XORI: alu_imm_form(ALU_XOR);
			OP_NOT: alu_reg_form(ALU_NOT);
			OP_SL: alu_reg_form(ALU_SHL);
			OP_SR: alu_reg_form(ALU_SHR);
			OP_MOV: alu_reg_form(ALU_PASS_A);
			OP_LW: alu_imm_form(ALU_PASS_IMM);
			OP_LI: alu_imm_form(ALU_PASS_IMM);
			OP_SW: begin
				exp_alu_src = 1'b1;
				exp_alu_op = ALU_PASS_IMM;
				exp_mem_write = 1'b1;
			end
			OP_BEQ, OP_BNE, OP_BLT, OP_BLET, OP_BGT, OP_BGET: begin
				exp_alu_src = 1'b1;
				exp_alu_op = ALU_PASS_IMM;
				exp_is_branch = 1'b1;
			end
			OP_J: exp_pc_sel = PC_JUMP;
			OP_IN: begin
				exp_wb_sel = WB_INPUT;
				exp_reg_write = 1'b1;
			end
			OP_OUT: begin
				exp_alu_src = 1'b1;
				exp_alu_op = ALU_PASS_IMM;
				exp_out = 1'b1;
			end
			default: ;
		endcase
		if (op == OP_NOT || op == OP_MOV) exp_rd_sel = 1'b0; // Unary ops write rt
		if (op == OP_LW) exp_wb_sel = WB_MEM;
	endtask

	function automatic logic condition_holds(input opcode_t op, input logic lt,
			input logic gt, input logic eq);
		case (op)
			OP_BEQ: return eq;
			OP_BNE: return !eq;
			OP_BLT: return lt;
			OP_BLET: return lt || eq;
			OP_BGT: return gt;
			OP_BGET: return gt || eq;
			default: return 1'b0;
		endcase
	endfunction

	// Compares every output with the reference and works out the next wait state
	task automatic expect_outputs;
		logic stall_exp;
		logic accept_exp;
		logic restart_exp;
		pc_sel_t e_pc_sel;
		logic e_pc_write;
		logic e_pc_reset;
		logic e_reg_write;
		logic e_mem_write;
		logic e_out;
		decode_reference(opcode);
		stall_exp = 1'b0;
		accept_exp = 1'b0;
		restart_exp = 1'b0;
		model_next = model_state;
		if (reset) begin
			stall_exp = 1'b1;
			model_next = MODEL_RUNNING;
		end else if (opcode == OP_RESET) begin
			restart_exp = 1'b1; // Any state
			model_next = MODEL_RUNNING;
		end else if (model_state == MODEL_RUNNING) begin
			stall_exp = (opcode == OP_IN) || (opcode == OP_HALT);
			if (opcode == OP_IN) model_next = MODEL_WAIT_INPUT;
			if (opcode == OP_HALT) model_next = MODEL_HALTED;
		end else if (model_state == MODEL_WAIT_INPUT) begin
			accept_exp = input_valid;
			stall_exp = !input_valid;
			if (input_valid) model_next = MODEL_RUNNING;
		end else begin
			restart_exp = restart; // input_valid has no effect when halted
			stall_exp = !restart;
			if (restart) model_next = MODEL_RUNNING;
		end
		e_pc_sel = PC_HOLD;
		e_pc_write = 1'b0;
		e_pc_reset = restart_exp;
		e_reg_write = 1'b0;
		e_mem_write = 1'b0;
		e_out = 1'b0;
		if (!restart_exp && !stall_exp) begin
			e_pc_write = 1'b1;
			e_reg_write = exp_reg_write;
			e_mem_write = exp_mem_write;
			e_out = exp_out;
			if (accept_exp) e_pc_sel = PC_INC;
			else if (exp_is_branch)
				e_pc_sel = condition_holds(opcode, less, greater, equal) ? PC_BRANCH : PC_INC;
			else e_pc_sel = exp_pc_sel;
		end
		check_value("rd_sel", rd_sel, exp_rd_sel);
		check_value("alu_src", alu_src, exp_alu_src);
		check_value("wb_sel", wb_sel, exp_wb_sel);
		check_value("alu_op", alu_op, exp_alu_op);
		check_value("pc_sel", pc_sel, e_pc_sel);
		check_value("pc_write", pc_write, e_pc_write);
		check_value("pc_reset", pc_reset, e_pc_reset);
		check_value("reg_write", reg_write, e_reg_write);
		check_value("mem_write", mem_write, e_mem_write);
		check_value("out_strobe", out_strobe, e_out);
	endtask

	// One clock cycle: drive 1 ns after the edge, check once settled
	task automatic run_cycle(input opcode_t op, input logic [2:0] flags, input logic valid,
			input logic rst);
		@(posedge clock);
		model_state = model_next;
		#1;
		reset = hold_reset;
		opcode = op;
		{less, greater, equal} = flags;
		input_valid = valid;
		restart = rst;
		#1;
		expect_outputs();
	endtask

	task automatic test_reset;
		for (int n = 0; n < RESET_CYCLES; n++) begin
			run_cycle(opcode_t'($urandom_range(0, 63)), 3'($urandom_range(0, 7)),
				1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
			check_value("pc_sel", pc_sel, PC_HOLD);
			check_value("pc_reset", pc_reset, 1'b0);
		end
		hold_reset = 1'b0;
		run_cycle(OP_NOP, 3'b000, 1'b0, 1'b0);
		check_value("pc_write", pc_write, 1'b1);
		check_value("pc_sel", pc_sel, PC_INC);
	endtask

	task automatic test_decode;
		opcode_t ops[$];
		opcode_t tmp;
		int j;
		for (int k = OP_ADD; k <= OP_SW; k++) begin
			if (k != OP_LA) ops.push_back(opcode_t'(k));
		end
		ops.push_back(OP_OUT);
		for (int i = ops.size() - 1; i > 0; i--) begin // Shuffle
			j = $urandom_range(0, i);
			tmp = ops[i];
			ops[i] = ops[j];
			ops[j] = tmp;
		end
		foreach (ops[i]) run_cycle(ops[i], 3'($urandom_range(0, 7)), 1'b0, 1'b0);
	endtask

	task automatic test_branches;
		for (int k = OP_BEQ; k <= OP_BGET; k++) begin
			for (int f = 0; f < 8; f++) begin
				run_cycle(opcode_t'(k), 3'(f), 1'b0, 1'b0);
				check_value("reg_write", reg_write, 1'b0);
				check_value("mem_write", mem_write, 1'b0);
			end
		end
		run_cycle(OP_J, 3'($urandom_range(0, 7)), 1'b0, 1'b0);
		check_value("pc_sel", pc_sel, PC_JUMP);
	endtask

	task automatic test_unused_opcodes;
		run_cycle(OP_LA, 3'b000, 1'b0, 1'b0);
		run_cycle(OP_JAL, 3'b111, 1'b0, 1'b0);
		run_cycle(OP_JR, 3'b010, 1'b0, 1'b0);
		repeat (8) begin
			run_cycle(opcode_t'($urandom_range(OP_OUT + 1, OP_RESET - 1)),
				3'($urandom_range(0, 7)), 1'b0, 1'b0);
			check_value("pc_sel", pc_sel, PC_INC);
		end
	endtask

	task automatic test_input_wait;
		int extra;
		extra = $urandom_range(0, 5);
		run_cycle(OP_IN, 3'b001, 1'b0, 1'b0); // First IN cycle stalls
		check_value("pc_write", pc_write, 1'b0);
		for (int n = 0; n < extra; n++) begin
			run_cycle(OP_IN, 3'($urandom_range(0, 7)), 1'b0, n == 0); // restart ignored
			check_value("reg_write", reg_write, 1'b0);
		end
		run_cycle(OP_IN, 3'b100, 1'b1, 1'b0);
		check_value("reg_write", reg_write, 1'b1);
		check_value("wb_sel", wb_sel, WB_INPUT);
		check_value("pc_sel", pc_sel, PC_INC);
		run_cycle(OP_ADD, 3'b000, 1'b0, 1'b0);
		check_value("alu_op", alu_op, ALU_ADD);
	endtask

	task automatic test_halt_reset;
		run_cycle(OP_HALT, 3'b000, 1'b0, 1'b0);
		check_value("pc_write", pc_write, 1'b0);
		run_cycle(OP_HALT, 3'b000, 1'b1, 1'b0); // Input strobe must not release
		check_value("pc_write", pc_write, 1'b0);
		run_cycle(OP_HALT, 3'b000, 1'b0, 1'b1);
		check_value("pc_reset", pc_reset, 1'b1);
		run_cycle(OP_NOP, 3'b000, 1'b0, 1'b0);
		check_value("pc_write", pc_write, 1'b1);
		run_cycle(OP_RESET, 3'b000, 1'b0, 1'b0);
		check_value("pc_reset", pc_reset, 1'b1);
		run_cycle(OP_HALT, 3'b000, 1'b0, 1'b0);
		run_cycle(OP_RESET, 3'b000, 1'b0, 1'b0); // RESET opcode also leaves HALT
		check_value("pc_reset", pc_reset, 1'b1);
		run_cycle(OP_SW, 3'b000, 1'b0, 1'b0);
		check_value("mem_write", mem_write, 1'b1);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$fatal(1, "Simulation timeout");
		end
	end

	initial begin
		void'($urandom(32'h281f_cb65));
		cycle_count = 0;
		hold_reset = 1'b1;
		reset = 1'b1;
		restart = 1'b0;
		input_valid = 1'b0;
		opcode = OP_NOP;
		less = 1'b0;
		greater = 1'b0;
		equal = 1'b0;
		model_state = MODEL_RUNNING;
		model_next = MODEL_RUNNING;
		test_reset();
		test_decode();
		test_branches();
		test_unused_opcodes();
		test_input_wait();
		test_halt_reset();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
source/control_pkg.sv
source/instruction_decoder.sv
source/wait_controller.sv
source/issue_control.sv
source/control_unit.sv
verif/tb_clock_gen.sv
verif/control_unit_tb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - source/control_pkg.sv
  - source/instruction_decoder.sv
  - source/wait_controller.sv
  - source/issue_control.sv
  - source/control_unit.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/control_unit_tb.sv
